// File: sim.f
+incdir+.
mem_mgr_pkg.sv
slot_op_decoder.sv
reg_slot.sv
mem_mgr_top.sv
mem_mgr_properties.sv
mem_mgr_tb.sv

// File: Bender.yml
package:
  name: mem_mgr

sources:
  - include_dirs:
      - .
    files:
      - mem_mgr_pkg.sv
      - slot_op_decoder.sv
      - reg_slot.sv
      - mem_mgr_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - mem_mgr_properties.sv
      - mem_mgr_tb.sv

// File: mem_mgr_tb.sv
`include "mem_mgr_cfg.svh"

module mem_mgr_tb;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int MEM_WORDS = 256;
  // code sits below the register file and the pointer targets
  localparam logic [`MM_DATA_W-1:0] CODE_BASE = 32'd16;
  localparam logic [`MM_DATA_W-1:0] DATA_BASE = 32'd128;
  localparam int IP_START = 4;
  localparam int NUM_INSTR = 8;
  // about 820 cycles for 8 instr x 17 states x 6 cycles, doubled with margin
  localparam int TIMEOUT_CYCLES = 2000;

  logic                    clk;
  logic                    rst;
  mem_mgr_pkg::mm_state_e  state;
  logic [`MM_DATA_W-1:0]   base_addr;
  logic [`MM_DATA_W-1:0]   base_addr_data;
  logic [`MM_DATA_W-1:0]   alu_result;
  mem_mgr_pkg::mem_rsp_t   mem_rsp;
  mem_mgr_pkg::mem_req_t   mem_req;
  mem_mgr_pkg::cmd_word_u  command_word;
  mem_mgr_pkg::operands_t  operands;
  logic                    next_state;

  // memory model and its expected image
  logic [`MM_DATA_W-1:0]   mem [MEM_WORDS];
  logic [`MM_DATA_W-1:0]   ref_mem [MEM_WORDS];
  logic [31:0]             stim_rng;
  logic [31:0]             wait_rng;
  logic                    pending;
  int                      wait_left;
  int                      cycle_cnt;

  mem_mgr_top i_dut (
    .clk            (clk),
    .rst            (rst),
    .state          (state),
    .base_addr      (base_addr),
    .base_addr_data (base_addr_data),
    .alu_result     (alu_result),
    .mem_rsp        (mem_rsp),
    .mem_req        (mem_req),
    .command_word   (command_word),
    .operands       (operands),
    .next_state     (next_state)
  );

  bind mem_mgr_top mem_mgr_properties i_props (
    .clk        (clk),
    .rst        (rst),
    .mem_req    (mem_req),
    .mem_rsp    (mem_rsp),
    .next_state (next_state)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // draws from the stimulus stream only
  function automatic logic [31:0] rand_below(input logic [31:0] n);
    stim_rng = xorshift32(stim_rng);
    return stim_rng % n;
  endfunction

  // pointer after write_prep by the flags
  function automatic logic [31:0] updated_ptr(input logic [31:0] p, input logic is_ptr,
                                              input logic [1:0] flags);
    if (is_ptr && flags == 2'b01) begin
      return p + 32'd1;
    end
    if (is_ptr && flags == 2'b10) begin
      return p - 32'd1;
    end
    return p;
  endfunction

  // read and read_p and write states per operand
  function automatic mem_mgr_pkg::mm_state_e operand_state(input int k, input int phase);
    mem_mgr_pkg::mm_state_e st [3];
    case (k)
      0: st = '{mem_mgr_pkg::ST_READ_COND, mem_mgr_pkg::ST_READ_COND_P,
                mem_mgr_pkg::ST_WRITE_COND};
      1: st = '{mem_mgr_pkg::ST_READ_SRC1, mem_mgr_pkg::ST_READ_SRC1_P,
                mem_mgr_pkg::ST_WRITE_SRC1};
      default: st = '{mem_mgr_pkg::ST_READ_SRC0, mem_mgr_pkg::ST_READ_SRC0_P,
                      mem_mgr_pkg::ST_WRITE_SRC0};
    endcase
    return st[phase];
  endfunction

  function automatic logic [`MM_DATA_W-1:0] operand_value(input int k);
    case (k)
      0: return operands.cond;
      1: return operands.src1;
      default: return operands.src0;
    endcase
  endfunction

  task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("FAILED at %0d ns: %s expected %h, got %h", $time, name, exp, got);
      $display("RESULT: FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  // random code and flags and pointer bits with registers 0..14
  function automatic logic [`MM_DATA_W-1:0] random_command();
    mem_mgr_pkg::cmd_word_u cw;
    stim_rng = xorshift32(stim_rng);
    cw.raw = stim_rng;
    cw.f.cond_reg = `MM_REG_NUM_W'(rand_below(15));
    cw.f.dst_reg  = `MM_REG_NUM_W'(rand_below(15));
    cw.f.src0_reg = `MM_REG_NUM_W'(rand_below(15));
    cw.f.src1_reg = `MM_REG_NUM_W'(rand_below(15));
    return cw.raw;
  endfunction

  task automatic fill_memory();
    // pattern from the whole address catches wrong reads
    for (int a = 0; a < MEM_WORDS; a++) begin
      mem[a] = 32'hc0de_0000 ^ (32'(a) * 32'h0001_0003);
    end
    // register words point into 144..246 with drift room
    for (int i = 0; i < `MM_REG_IP; i++) begin
      mem[DATA_BASE + i] = 32'd24 + rand_below(87);
    end
    mem[DATA_BASE + `MM_REG_IP] = IP_START;
    for (int i = 0; i < NUM_INSTR; i++) begin
      mem[CODE_BASE + IP_START + i] = random_command();
    end
    for (int a = 0; a < MEM_WORDS; a++) begin
      ref_mem[a] = mem[a];
    end
  endtask

  // set a state and wait for its next_state pulse
  task automatic run_step(input mem_mgr_pkg::mm_state_e st);
    state = st;
    do begin
      @(posedge clk);
      #2;
    end while (!next_state);
  endtask

  task automatic run_instr();
    mem_mgr_pkg::cmd_word_u    cw;
    logic [`MM_DATA_W-1:0]     ip;
    logic [`MM_REG_NUM_W-1:0]  regs [4];
    logic                      is_ptr [4];
    logic [1:0]                flags [4];
    logic [`MM_DATA_W-1:0]     ptrs [4];
    logic [`MM_DATA_W-1:0]     exp_val;
    logic [`MM_DATA_W-1:0]     alu;
    logic [`MM_DATA_W-1:0]     addr;
    string                     names [3];
    names = '{"operands.cond", "operands.src1", "operands.src0"};
    ip = ref_mem[DATA_BASE + `MM_REG_IP];
    cw.raw = ref_mem[CODE_BASE + ip];
    run_step(mem_mgr_pkg::ST_READ_CMD);
    run_step(mem_mgr_pkg::ST_READ_CMD_P);
    check_word("command_word", command_word.raw, cw.raw);
    // index order is cond src1 src0 dst
    regs[0]   = cw.f.cond_reg;
    is_ptr[0] = cw.f.cond_ptr;
    flags[0]  = cw.f.cond_flags;
    regs[1]   = cw.f.src1_reg;
    is_ptr[1] = cw.f.src1_ptr;
    flags[1]  = cw.f.src1_flags;
    regs[2]   = cw.f.src0_reg;
    is_ptr[2] = cw.f.src0_ptr;
    flags[2]  = cw.f.src0_flags;
    regs[3]   = cw.f.dst_reg;
    is_ptr[3] = cw.f.dst_ptr;
    flags[3]  = cw.f.dst_flags;
    // all reads come before any write of this instruction
    for (int k = 0; k < 4; k++) begin
      ptrs[k] = ref_mem[DATA_BASE + regs[k]];
    end
    for (int k = 0; k < 3; k++) begin
      run_step(operand_state(k, 0));
      run_step(operand_state(k, 1));
      exp_val = is_ptr[k] ? ref_mem[DATA_BASE + ptrs[k]] : ptrs[k];
      check_word(names[k], operand_value(k), exp_val);
    end
    run_step(mem_mgr_pkg::ST_READ_DST);
    // result also usable as a pointer later
    alu = 32'd24 + rand_below(87);
    alu_result = alu;
    run_step(mem_mgr_pkg::ST_ALU_RESULTS);
    check_word("operands.dst", operands.dst, alu);
    run_step(mem_mgr_pkg::ST_WRITE_PREP);
    run_step(mem_mgr_pkg::ST_WRITE_DST_P);
    // store goes through the already updated dst pointer
    addr = is_ptr[3] ? DATA_BASE + updated_ptr(ptrs[3], 1'b1, flags[3])
                     : DATA_BASE + regs[3];
    ref_mem[addr] = alu;
    check_word($sformatf("mem[%0d]", addr), mem[addr], alu);
    run_step(mem_mgr_pkg::ST_WRITE_REG_IP);
    ref_mem[DATA_BASE + `MM_REG_IP] = ip + 32'd1;
    check_word("mem[ip register]", mem[DATA_BASE + `MM_REG_IP], ip + 32'd1);
    for (int k = 0; k < 3; k++) begin
      run_step(operand_state(k, 2));
      addr = DATA_BASE + regs[k];
      // only 01 and 10 write the register back
      if (flags[k] == 2'b01 || flags[k] == 2'b10) begin
        ref_mem[addr] = updated_ptr(ptrs[k], is_ptr[k], flags[k]);
      end
      check_word($sformatf("mem[%0d]", addr), mem[addr], ref_mem[addr]);
    end
    // nothing else touched
    for (int a = 0; a < MEM_WORDS; a++) begin
      check_word($sformatf("mem[%0d]", a), mem[a], ref_mem[a]);
    end
  endtask

  // memory model answering after 0 to 3 wait cycles
  always @(posedge clk) begin
    #2;
    mem_rsp = '0;
    if (rst) begin
      pending = 1'b0;
    end else if (mem_req.read_q || mem_req.write_q) begin
      if (!pending) begin
        pending = 1'b1;
        wait_rng = xorshift32(wait_rng);
        wait_left = int'(wait_rng % 4);
      end
      if (wait_left != 0) begin
        wait_left--;
      end else if (mem_req.addr >= MEM_WORDS) begin
        $display("memory access outside the model at address %0d", mem_req.addr);
        $display("RESULT: FAIL");
        $fatal(1, "bad address");
      end else begin
        pending = 1'b0;
        if (mem_req.read_q) begin
          mem_rsp.read_dn = 1'b1;
          mem_rsp.rdata   = mem[mem_req.addr];
        end else begin
          mem[mem_req.addr] = mem_req.wdata;
          mem_rsp.write_dn  = 1'b1;
        end
      end
    end
  end

  // stall limit and protocol watch
  always @(posedge clk) begin
    #2;
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("run stalled, no end after %0d cycles", cycle_cnt);
      $display("RESULT: FAIL");
      $fatal(1, "timeout");
    end else if (i_dut.i_props.fail_cnt != 0) begin
      $display("bus protocol assertion failed at %0d ns", $time);
      $display("RESULT: FAIL");
      $fatal(1, "protocol failure");
    end
  end

  initial begin
    rst            = 1'b1;
    state          = mem_mgr_pkg::ST_IDLE;
    base_addr      = CODE_BASE;
    base_addr_data = DATA_BASE;
    alu_result     = '0;
    mem_rsp        = '0;
    stim_rng       = 32'd72;
    wait_rng       = 32'd72;
    pending        = 1'b0;
    wait_left      = 0;
    cycle_cnt      = 0;
    fill_memory();
    repeat (3) @(posedge clk);
    #2;
    rst = 1'b0;
    for (int n = 0; n < NUM_INSTR; n++) begin
      run_instr();
    end
    state = mem_mgr_pkg::ST_IDLE;
    @(posedge clk);
    #2;
    if (i_dut.i_props.fail_cnt == 0) begin
      $display("RESULT: PASS");
      $finish;
    end else begin
      $display("RESULT: FAIL");
      $fatal(1, "protocol failure");
    end
  end

endmodule

// File: mem_mgr_properties.sv
module mem_mgr_properties (
  input  logic                   clk,
  input  logic                   rst,
  input  mem_mgr_pkg::mem_req_t  mem_req,
  input  mem_mgr_pkg::mem_rsp_t  mem_rsp,
  input  logic                   next_state
);

  timeunit 1ns;
  timeprecision 100ps;

  // failures so far, watched by the testbench
  int fail_cnt = 0;

  // one direction at a time on the bus
  a_no_read_and_write: assert property (@(posedge clk) disable iff (rst)
    !(mem_req.read_q && mem_req.write_q))
    else begin
      $error("read_q and write_q high together");
      fail_cnt++;
    end

  // read request held with a steady address until read_dn
  a_read_hold: assert property (@(posedge clk) disable iff (rst)
    (mem_req.read_q && !mem_rsp.read_dn) |=> (mem_req.read_q && $stable(mem_req.addr)))
    else begin
      $error("read request dropped or address moved before read_dn");
      fail_cnt++;
    end

  // write request keeps addr and wdata until write_dn
  a_write_hold: assert property (@(posedge clk) disable iff (rst)
    (mem_req.write_q && !mem_rsp.write_dn) |=>
      (mem_req.write_q && $stable(mem_req.addr) && $stable(mem_req.wdata)))
    else begin
      $error("write request dropped or changed before write_dn");
      fail_cnt++;
    end

  // done clears the request next cycle
  a_read_drop: assert property (@(posedge clk) disable iff (rst)
    (mem_req.read_q && mem_rsp.read_dn) |=> !mem_req.read_q)
    else begin
      $error("read_q still high after read_dn");
      fail_cnt++;
    end

  a_write_drop: assert property (@(posedge clk) disable iff (rst)
    (mem_req.write_q && mem_rsp.write_dn) |=> !mem_req.write_q)
    else begin
      $error("write_q still high after write_dn");
      fail_cnt++;
    end

  // step end is a single-cycle pulse
  a_step_pulse: assert property (@(posedge clk) disable iff (rst)
    next_state |=> !next_state)
    else begin
      $error("next_state longer than one cycle");
      fail_cnt++;
    end

  // bus and step outputs quiet while in reset
  a_reset_quiet: assert property (@(posedge clk)
    rst |=> (!mem_req.read_q && !mem_req.write_q && !next_state))
    else begin
      $error("request or next_state during reset");
      fail_cnt++;
    end

endmodule

// File: mem_mgr_top.sv
`include "mem_mgr_cfg.svh"

module mem_mgr_top (
  input  logic                    clk,
  input  logic                    rst,
  input  mem_mgr_pkg::mm_state_e  state,
  input  logic [`MM_DATA_W-1:0]   base_addr,
  input  logic [`MM_DATA_W-1:0]   base_addr_data,
  input  logic [`MM_DATA_W-1:0]   alu_result,
  input  mem_mgr_pkg::mem_rsp_t   mem_rsp,
  output mem_mgr_pkg::mem_req_t   mem_req,
  output mem_mgr_pkg::cmd_word_u  command_word,
  output mem_mgr_pkg::operands_t  operands,
  output logic                    next_state
);

  // per-slot op starts from the decoder
  mem_mgr_pkg::reg_op_e [`MM_NUM_SLOTS-1:0] slot_ops;
  mem_mgr_pkg::mem_req_t                    slot_req [`MM_NUM_SLOTS];
  logic [`MM_NUM_SLOTS-1:0]                 slot_done;
  // fetched command as a raw word
  logic [`MM_DATA_W-1:0]                    cmd_value;

  slot_op_decoder i_decoder (
    .clk      (clk),
    .rst      (rst),
    .state    (state),
    .slot_ops (slot_ops)
  );

  // ip slot, its value is the command word
  reg_slot #(.SLOT(mem_mgr_pkg::SLOT_CMD)) i_slot_cmd (
    .clk            (clk),
    .rst            (rst),
    .op             (slot_ops[mem_mgr_pkg::SLOT_CMD]),
    .command_word   (command_word),
    .base_addr      (base_addr),
    .base_addr_data (base_addr_data),
    .alu_result     (alu_result),
    .mem_rsp        (mem_rsp),
    .mem_req        (slot_req[mem_mgr_pkg::SLOT_CMD]),
    .ptr            (),
    .value          (cmd_value),
    .done           (slot_done[mem_mgr_pkg::SLOT_CMD])
  );

  reg_slot #(.SLOT(mem_mgr_pkg::SLOT_COND)) i_slot_cond (
    .clk            (clk),
    .rst            (rst),
    .op             (slot_ops[mem_mgr_pkg::SLOT_COND]),
    .command_word   (command_word),
    .base_addr      (base_addr),
    .base_addr_data (base_addr_data),
    .alu_result     (alu_result),
    .mem_rsp        (mem_rsp),
    .mem_req        (slot_req[mem_mgr_pkg::SLOT_COND]),
    .ptr            (),
    .value          (operands.cond),
    .done           (slot_done[mem_mgr_pkg::SLOT_COND])
  );

  reg_slot #(.SLOT(mem_mgr_pkg::SLOT_SRC1)) i_slot_src1 (
    .clk            (clk),
    .rst            (rst),
    .op             (slot_ops[mem_mgr_pkg::SLOT_SRC1]),
    .command_word   (command_word),
    .base_addr      (base_addr),
    .base_addr_data (base_addr_data),
    .alu_result     (alu_result),
    .mem_rsp        (mem_rsp),
    .mem_req        (slot_req[mem_mgr_pkg::SLOT_SRC1]),
    .ptr            (),
    .value          (operands.src1),
    .done           (slot_done[mem_mgr_pkg::SLOT_SRC1])
  );

  reg_slot #(.SLOT(mem_mgr_pkg::SLOT_SRC0)) i_slot_src0 (
    .clk            (clk),
    .rst            (rst),
    .op             (slot_ops[mem_mgr_pkg::SLOT_SRC0]),
    .command_word   (command_word),
    .base_addr      (base_addr),
    .base_addr_data (base_addr_data),
    .alu_result     (alu_result),
    .mem_rsp        (mem_rsp),
    .mem_req        (slot_req[mem_mgr_pkg::SLOT_SRC0]),
    .ptr            (),
    .value          (operands.src0),
    .done           (slot_done[mem_mgr_pkg::SLOT_SRC0])
  );

  // dst catches the alu result and stores it
  reg_slot #(.SLOT(mem_mgr_pkg::SLOT_DST)) i_slot_dst (
    .clk            (clk),
    .rst            (rst),
    .op             (slot_ops[mem_mgr_pkg::SLOT_DST]),
    .command_word   (command_word),
    .base_addr      (base_addr),
    .base_addr_data (base_addr_data),
    .alu_result     (alu_result),
    .mem_rsp        (mem_rsp),
    .mem_req        (slot_req[mem_mgr_pkg::SLOT_DST]),
    .ptr            (),
    .value          (operands.dst),
    .done           (slot_done[mem_mgr_pkg::SLOT_DST])
  );

  // operand slots decode this through the field view
  assign command_word.raw = cmd_value;

  // one slot on the bus at a time, the rest are zero
  always_comb begin
    mem_req = '0;
    for (int i = 0; i < `MM_NUM_SLOTS; i++) begin
      mem_req = mem_req | slot_req[i];
    end
  end

  // write_prep finishes all slots in the same cycle
  assign next_state = |slot_done;

endmodule

// File: reg_slot.sv
`include "mem_mgr_cfg.svh"

module reg_slot #(
  parameter mem_mgr_pkg::slot_e SLOT = mem_mgr_pkg::SLOT_CMD
) (
  input  logic                    clk,
  input  logic                    rst,
  input  mem_mgr_pkg::reg_op_e    op,
  input  mem_mgr_pkg::cmd_word_u  command_word,
  input  logic [`MM_DATA_W-1:0]   base_addr,
  input  logic [`MM_DATA_W-1:0]   base_addr_data,
  input  logic [`MM_DATA_W-1:0]   alu_result,
  input  mem_mgr_pkg::mem_rsp_t   mem_rsp,
  output mem_mgr_pkg::mem_req_t   mem_req,
  output logic [`MM_DATA_W-1:0]   ptr,
  output logic [`MM_DATA_W-1:0]   value,
  output logic                    done
);

  // waiting for a read into ptr, a read into value, or a write
  typedef enum logic [1:0] {
    FS_IDLE,
    FS_READ_PTR,
    FS_READ_VAL,
    FS_WRITE
  } fsm_e;

  // operand source of this slot
  logic [`MM_REG_NUM_W-1:0] reg_num;
  logic                     is_ptr;
  logic [1:0]               flags;
  logic [`MM_DATA_W-1:0]    reg_addr;
  logic [`MM_DATA_W-1:0]    ptr_addr;
  logic                     upd_flags;

  fsm_e                     fsm_q;
  mem_mgr_pkg::mem_req_t    req_q;
  logic [`MM_DATA_W-1:0]    ptr_q;
  logic [`MM_DATA_W-1:0]    value_q;
  logic                     done_q;

  // pick own field of the command word
  always_comb begin
    case (SLOT)
      // ip is always a post-incremented pointer
      mem_mgr_pkg::SLOT_CMD: begin
        reg_num = `MM_REG_NUM_W'(`MM_REG_IP);
        is_ptr  = 1'b1;
        flags   = 2'b01;
      end
      mem_mgr_pkg::SLOT_COND: begin
        reg_num = command_word.f.cond_reg;
        is_ptr  = command_word.f.cond_ptr;
        flags   = command_word.f.cond_flags;
      end
      mem_mgr_pkg::SLOT_SRC1: begin
        reg_num = command_word.f.src1_reg;
        is_ptr  = command_word.f.src1_ptr;
        flags   = command_word.f.src1_flags;
      end
      mem_mgr_pkg::SLOT_SRC0: begin
        reg_num = command_word.f.src0_reg;
        is_ptr  = command_word.f.src0_ptr;
        flags   = command_word.f.src0_flags;
      end
      default: begin
        reg_num = command_word.f.dst_reg;
        is_ptr  = command_word.f.dst_ptr;
        flags   = command_word.f.dst_flags;
      end
    endcase
  end

  // register file sits at base_addr_data
  assign reg_addr  = base_addr_data + `MM_DATA_W'(reg_num);
  // code space for ip, data space for operands
  assign ptr_addr  = (SLOT == mem_mgr_pkg::SLOT_CMD) ? (base_addr + ptr_q)
                                                    : (base_addr_data + ptr_q);
  // 01 increment, 10 decrement
  assign upd_flags = (flags == 2'b01) || (flags == 2'b10);

  always_ff @(posedge clk) begin
    if (rst) begin
      fsm_q   <= FS_IDLE;
      req_q   <= '0;
      ptr_q   <= '0;
      value_q <= '0;
      done_q  <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (fsm_q)
        FS_IDLE: begin
          case (op)
            mem_mgr_pkg::OP_READ: begin
              req_q.read_q <= 1'b1;
              req_q.addr   <= reg_addr;
              fsm_q        <= FS_READ_PTR;
            end
            mem_mgr_pkg::OP_READ_P: begin
              if (is_ptr) begin
                req_q.read_q <= 1'b1;
                req_q.addr   <= ptr_addr;
                fsm_q        <= FS_READ_VAL;
              end else begin
                // plain register, value is the word itself
                value_q <= ptr_q;
                done_q  <= 1'b1;
              end
            end
            mem_mgr_pkg::OP_CATCH: begin
              value_q <= alu_result;
              done_q  <= 1'b1;
            end
            mem_mgr_pkg::OP_WRITE_PREP: begin
              if (is_ptr && flags == 2'b01) begin
                ptr_q <= ptr_q + `MM_DATA_W'(1);
              end else if (is_ptr && flags == 2'b10) begin
                ptr_q <= ptr_q - `MM_DATA_W'(1);
              end
              done_q <= 1'b1;
            end
            mem_mgr_pkg::OP_WRITE: begin
              if (upd_flags) begin
                req_q.write_q <= 1'b1;
                req_q.addr    <= reg_addr;
                req_q.wdata   <= ptr_q;
                fsm_q         <= FS_WRITE;
              end else begin
                // nothing changed, skip the bus
                done_q <= 1'b1;
              end
            end
            mem_mgr_pkg::OP_WRITE_P: begin
              req_q.write_q <= 1'b1;
              req_q.addr    <= is_ptr ? ptr_addr : reg_addr;
              req_q.wdata   <= value_q;
              fsm_q         <= FS_WRITE;
            end
            default: begin
            end
          endcase
        end
        // hold the request until the memory answers
        FS_READ_PTR: begin
          if (mem_rsp.read_dn) begin
            ptr_q  <= mem_rsp.rdata;
            req_q  <= '0;
            done_q <= 1'b1;
            fsm_q  <= FS_IDLE;
          end
        end
        FS_READ_VAL: begin
          if (mem_rsp.read_dn) begin
            value_q <= mem_rsp.rdata;
            req_q   <= '0;
            done_q  <= 1'b1;
            fsm_q   <= FS_IDLE;
          end
        end
        FS_WRITE: begin
          if (mem_rsp.write_dn) begin
            req_q  <= '0;
            done_q <= 1'b1;
            fsm_q  <= FS_IDLE;
          end
        end
        default: fsm_q <= FS_IDLE;
      endcase
    end
  end

  // idle slot drives zeros, top or-merges
  assign mem_req = req_q;
  assign ptr     = ptr_q;
  assign value   = value_q;
  assign done    = done_q;

endmodule

// File: slot_op_decoder.sv
`include "mem_mgr_cfg.svh"

module slot_op_decoder (
  input  logic                                      clk,
  input  logic                                      rst,
  input  mem_mgr_pkg::mm_state_e                    state,
  output mem_mgr_pkg::reg_op_e [`MM_NUM_SLOTS-1:0]  slot_ops
);

  // last seen state, to spot a new step
  mem_mgr_pkg::mm_state_e                   prev_state;
  // ops for the coming cycle
  mem_mgr_pkg::reg_op_e [`MM_NUM_SLOTS-1:0] ops_d;
  logic                                     state_chg;

  assign state_chg = (state != prev_state);

  always_comb begin
    for (int i = 0; i < `MM_NUM_SLOTS; i++) begin
      ops_d[i] = mem_mgr_pkg::OP_NULL;
    end
    // only a fresh state starts work
    if (state_chg) begin
      case (state)
        // instruction fetch
        mem_mgr_pkg::ST_READ_CMD:
          ops_d[mem_mgr_pkg::SLOT_CMD] = mem_mgr_pkg::OP_READ;
        mem_mgr_pkg::ST_READ_CMD_P:
          ops_d[mem_mgr_pkg::SLOT_CMD] = mem_mgr_pkg::OP_READ_P;
        // operand reads
        mem_mgr_pkg::ST_READ_COND:
          ops_d[mem_mgr_pkg::SLOT_COND] = mem_mgr_pkg::OP_READ;
        mem_mgr_pkg::ST_READ_COND_P:
          ops_d[mem_mgr_pkg::SLOT_COND] = mem_mgr_pkg::OP_READ_P;
        mem_mgr_pkg::ST_READ_SRC1:
          ops_d[mem_mgr_pkg::SLOT_SRC1] = mem_mgr_pkg::OP_READ;
        mem_mgr_pkg::ST_READ_SRC1_P:
          ops_d[mem_mgr_pkg::SLOT_SRC1] = mem_mgr_pkg::OP_READ_P;
        mem_mgr_pkg::ST_READ_SRC0:
          ops_d[mem_mgr_pkg::SLOT_SRC0] = mem_mgr_pkg::OP_READ;
        mem_mgr_pkg::ST_READ_SRC0_P:
          ops_d[mem_mgr_pkg::SLOT_SRC0] = mem_mgr_pkg::OP_READ_P;
        // dst only needs its pointer
        mem_mgr_pkg::ST_READ_DST:
          ops_d[mem_mgr_pkg::SLOT_DST] = mem_mgr_pkg::OP_READ;
        mem_mgr_pkg::ST_ALU_RESULTS:
          ops_d[mem_mgr_pkg::SLOT_DST] = mem_mgr_pkg::OP_CATCH;
        // every slot updates its pointer at once, no bus
        mem_mgr_pkg::ST_WRITE_PREP: begin
          for (int i = 0; i < `MM_NUM_SLOTS; i++) begin
            ops_d[i] = mem_mgr_pkg::OP_WRITE_PREP;
          end
        end
        mem_mgr_pkg::ST_WRITE_DST_P:
          ops_d[mem_mgr_pkg::SLOT_DST] = mem_mgr_pkg::OP_WRITE_P;
        // pointer write-backs
        mem_mgr_pkg::ST_WRITE_REG_IP:
          ops_d[mem_mgr_pkg::SLOT_CMD] = mem_mgr_pkg::OP_WRITE;
        mem_mgr_pkg::ST_WRITE_COND:
          ops_d[mem_mgr_pkg::SLOT_COND] = mem_mgr_pkg::OP_WRITE;
        mem_mgr_pkg::ST_WRITE_SRC1:
          ops_d[mem_mgr_pkg::SLOT_SRC1] = mem_mgr_pkg::OP_WRITE;
        mem_mgr_pkg::ST_WRITE_SRC0:
          ops_d[mem_mgr_pkg::SLOT_SRC0] = mem_mgr_pkg::OP_WRITE;
        // idle issues nothing
        default: begin
        end
      endcase
    end
  end

  // ops held one cycle, NULL otherwise
  always_ff @(posedge clk) begin
    if (rst) begin
      prev_state <= mem_mgr_pkg::ST_IDLE;
      for (int i = 0; i < `MM_NUM_SLOTS; i++) begin
        slot_ops[i] <= mem_mgr_pkg::OP_NULL;
      end
    end else begin
      prev_state <= state;
      slot_ops   <= ops_d;
    end
  end

endmodule

// File: mem_mgr_pkg.sv
`include "mem_mgr_cfg.svh"

package mem_mgr_pkg;

  // sequencer state codes
  typedef enum logic [4:0] {
    ST_IDLE         = 5'd0,
    ST_READ_CMD     = 5'd1,
    ST_READ_CMD_P   = 5'd2,
    ST_READ_COND    = 5'd3,
    ST_READ_COND_P  = 5'd4,
    ST_READ_SRC1    = 5'd5,
    ST_READ_SRC1_P  = 5'd6,
    ST_READ_SRC0    = 5'd7,
    ST_READ_SRC0_P  = 5'd8,
    ST_READ_DST     = 5'd9,
    ST_ALU_RESULTS  = 5'd10,
    ST_WRITE_PREP   = 5'd11,
    ST_WRITE_DST_P  = 5'd12,
    ST_WRITE_REG_IP = 5'd13,
    ST_WRITE_COND   = 5'd14,
    ST_WRITE_SRC1   = 5'd15,
    ST_WRITE_SRC0   = 5'd16
  } mm_state_e;

  // one operation for one slot
  typedef enum logic [2:0] {
    OP_NULL       = 3'd0,
    OP_READ       = 3'd1,
    OP_READ_P     = 3'd2,
    OP_CATCH      = 3'd3,
    OP_WRITE_PREP = 3'd4,
    OP_WRITE      = 3'd5,
    OP_WRITE_P    = 3'd6
  } reg_op_e;

  // slot ids, also index into the op vector
  typedef enum logic [2:0] {
    SLOT_CMD  = 3'd0,
    SLOT_COND = 3'd1,
    SLOT_SRC1 = 3'd2,
    SLOT_SRC0 = 3'd3,
    SLOT_DST  = 3'd4
  } slot_e;

  // command word fields, msb first
  typedef struct packed {
    logic [3:0]                   cmd_code;
    logic [1:0]                   cond_flags;
    logic [1:0]                   dst_flags;
    logic [1:0]                   src0_flags;
    logic [1:0]                   src1_flags;
    logic                         cond_ptr;
    logic                         dst_ptr;
    logic                         src0_ptr;
    logic                         src1_ptr;
    logic [`MM_REG_NUM_W-1:0]     cond_reg;
    logic [`MM_REG_NUM_W-1:0]     dst_reg;
    logic [`MM_REG_NUM_W-1:0]     src0_reg;
    logic [`MM_REG_NUM_W-1:0]     src1_reg;
  } cmd_fields_t;

  // raw word as fetched, or decoded fields
  typedef union packed {
    logic [`MM_DATA_W-1:0] raw;
    cmd_fields_t           f;
  } cmd_word_u;

  // bus request, one per slot, or-merged at top
  typedef struct packed {
    logic                  read_q;
    logic                  write_q;
    logic [`MM_DATA_W-1:0] addr;
    logic [`MM_DATA_W-1:0] wdata;
  } mem_req_t;

  // bus response, shared by all slots
  typedef struct packed {
    logic                  read_dn;
    logic                  write_dn;
    logic [`MM_DATA_W-1:0] rdata;
  } mem_rsp_t;

  // operand values toward the alu
  typedef struct packed {
    logic [`MM_DATA_W-1:0] cond;
    logic [`MM_DATA_W-1:0] src1;
    logic [`MM_DATA_W-1:0] src0;
    logic [`MM_DATA_W-1:0] dst;
  } operands_t;

endpackage

// File: mem_mgr_cfg.svh
`ifndef MEM_MGR_CFG_SVH
`define MEM_MGR_CFG_SVH

// word width, also used for word addresses
`define MM_DATA_W 32

// register number field width
`define MM_REG_NUM_W 4

// instruction pointer lives in this register
`define MM_REG_IP 15

// cmd, cond, src1, src0, dst
`define MM_NUM_SLOTS 5

`endif
